// ==== common/nes_loader_pkg.sv ====
// Cartridge loader package
// Address map, iNES header constants, mapper flag layout and APB register map

`default_nettype none

package nes_loader_pkg;

	// Memory layout
	localparam int ADDR_W = 22;
	localparam logic [ADDR_W-1:0] PRG_BASE = 22'h000000;
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000;
	localparam int PRG_PAGE_SHIFT = 14; // 16 KB pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KB pages
	localparam int HEADER_LEN = 16;

	// "NES" followed by MS-DOS EOF
	localparam logic [7:0] INES_MAGIC0 = 8'h4E;
	localparam logic [7:0] INES_MAGIC1 = 8'h45;
	localparam logic [7:0] INES_MAGIC2 = 8'h53;
	localparam logic [7:0] INES_MAGIC3 = 8'h1A;

	// Mapper flag word layout
	localparam int FLAGS_W = 26;
	localparam int FLAG_MAPPER_LSB = 0;
	localparam int FLAG_PRG_SIZE_LSB = 8;
	localparam int FLAG_CHR_SIZE_LSB = 11;
	localparam int FLAG_MIRROR = 14;
	localparam int FLAG_CHR_RAM = 15;
	localparam int FLAG_FOUR_SCREEN = 16;
	localparam int FLAG_MAPPER2_LSB = 17;
	localparam int FLAG_HAS_SAVES = 25;

	// APB register map
	localparam int APB_ADDR_W = 4;
	localparam logic [APB_ADDR_W-1:0] REG_CTRL = 4'h0;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h4;
	localparam logic [APB_ADDR_W-1:0] REG_FLAGS = 4'h8;

	// Signature bytes in the upper half of a multitap read
	localparam logic [7:0] MULTITAP_SIG_P1 = 8'h08;
	localparam logic [7:0] MULTITAP_SIG_P2 = 8'h04;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} loader_state_t;

endpackage

`default_nettype wire

// ==== loader/ines_header_parser.sv ====
// iNES header parser
// Stores the 16 header bytes, validates magic and trainer,
// and assembles the mapper flag word

`timescale 1ns/1ps
`default_nettype none

module ines_header_parser (
	input  wire logic                              clk,
	input  wire logic                              reset_nes,
	input  wire logic                              hdr_valid,
	input  wire logic [3:0]                        hdr_index,
	input  wire logic [7:0]                        hdr_byte,
	input  wire logic                              invert_mirroring,
	output logic                                   header_ok,
	output logic [7:0]                             prg_pages,
	output logic [7:0]                             chr_pages,
	output logic [nes_loader_pkg::FLAGS_W-1:0]     flags
);
	import nes_loader_pkg::*;

	logic [7:0] hdr [HEADER_LEN];
	logic       hdr_complete;
	logic       is_nes20;
	logic       is_dirty;
	logic [7:0] mapper;
	logic [7:0] mapper2;

	// Ceiling of log2 of the page count, capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		if (pages <= 8'd1)       code = 3'd0;
		else if (pages <= 8'd2)  code = 3'd1;
		else if (pages <= 8'd4)  code = 3'd2;
		else if (pages <= 8'd8)  code = 3'd3;
		else if (pages <= 8'd16) code = 3'd4;
		else if (pages <= 8'd32) code = 3'd5;
		else if (pages <= 8'd64) code = 3'd6;
		else                     code = 3'd7;
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_valid)
			hdr[hdr_index] <= hdr_byte;
	end

	// First byte of a new file invalidates the old header
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			hdr_complete <= 1'b0;
		end else if (hdr_valid) begin
			if (hdr_index == 4'(HEADER_LEN - 1))
				hdr_complete <= 1'b1;
			else if (hdr_index == 4'd0)
				hdr_complete <= 1'b0;
		end
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	// Trainers are not supported
	assign header_ok = hdr_complete && hdr[0] == INES_MAGIC0 && hdr[1] == INES_MAGIC1 &&
		hdr[2] == INES_MAGIC2 && hdr[3] == INES_MAGIC3 && !hdr[6][2];

	assign is_nes20 = hdr[7][3:2] == 2'b10;

	// Junk in the padding bytes of an old-style header
	assign is_dirty = !is_nes20 && (hdr[9][7:1] != 7'd0 || hdr[10] != 8'd0 ||
		hdr[11] != 8'd0 || hdr[12] != 8'd0 || hdr[13] != 8'd0 ||
		hdr[14] != 8'd0 || hdr[15] != 8'd0);

	assign mapper = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	assign mapper2 = is_nes20 ? hdr[8] : 8'h00;

	always_comb begin
		flags = '0;
		flags[FLAG_MAPPER_LSB +: 8] = mapper;
		flags[FLAG_PRG_SIZE_LSB +: 3] = size_code(prg_pages);
		flags[FLAG_CHR_SIZE_LSB +: 3] = size_code(chr_pages);
		flags[FLAG_MIRROR] = hdr[6][0] ^ invert_mirroring;
		flags[FLAG_CHR_RAM] = chr_pages == 8'd0;
		flags[FLAG_FOUR_SCREEN] = hdr[6][3];
		flags[FLAG_MAPPER2_LSB +: 8] = mapper2;
		flags[FLAG_HAS_SAVES] = hdr[6][1]; // Battery bit
	end

endmodule

`default_nettype wire

// ==== loader/rom_loader.sv ====
// ROM loader
// Walks an iNES file byte by byte: header, PRG pages, CHR pages
// and writes the payload to memory

`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  wire logic                              clk,
	input  wire logic                              reset_nes,
	input  wire logic                              download,
	input  wire logic                              file_valid,
	input  wire logic [7:0]                        file_data,
	input  wire logic                              invert_mirroring,
	output logic [nes_loader_pkg::ADDR_W-1:0]      mem_addr,
	output logic [7:0]                             mem_data,
	output logic                                   mem_write,
	output logic                                   busy,
	output logic                                   done,
	output logic                                   error,
	output logic [nes_loader_pkg::FLAGS_W-1:0]     mapper_flags
);
	import nes_loader_pkg::*;

	loader_state_t      state;
	logic               download_q;
	logic               restart;
	logic [3:0]         hdr_cnt;
	logic               hdr_check; // All header bytes in, evaluate next
	logic [ADDR_W-1:0]  bytes_left;
	logic               hdr_valid;
	logic               header_ok;
	logic [7:0]         prg_pages;
	logic [7:0]         chr_pages;
	logic [FLAGS_W-1:0] flags;

	ines_header_parser u_ines_header_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.hdr_valid        (hdr_valid),
		.hdr_index        (hdr_cnt),
		.hdr_byte         (file_data),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (flags)
	);

	// A byte arriving with the download edge is dropped
	assign restart = download && !download_q;

	assign hdr_valid = file_valid && !restart && state == LOAD_HEADER && !hdr_check;
	assign mem_write = file_valid && !restart && (state == LOAD_PRG || state == LOAD_CHR) &&
		bytes_left != '0;
	assign mem_data = file_data;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			download_q <= 1'b0;
			state <= LOAD_HEADER;
			hdr_cnt <= 4'd0;
			hdr_check <= 1'b0;
			bytes_left <= '0;
			mem_addr <= PRG_BASE;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			download_q <= download;
			if (restart) begin
				state <= LOAD_HEADER;
				hdr_cnt <= 4'd0;
				hdr_check <= 1'b0;
				bytes_left <= '0;
				mem_addr <= PRG_BASE;
				busy <= 1'b0;
				done <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
				LOAD_HEADER: begin
					if (hdr_check) begin
						hdr_check <= 1'b0;
						if (header_ok) begin
							state <= LOAD_PRG;
							mem_addr <= PRG_BASE;
							bytes_left <= ADDR_W'(prg_pages) << PRG_PAGE_SHIFT;
						end else begin
							state <= LOAD_ERROR;
							busy <= 1'b0;
							done <= 1'b1;
							error <= 1'b1;
						end
					end else if (hdr_valid) begin
						busy <= 1'b1;
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'(HEADER_LEN - 1))
							hdr_check <= 1'b1;
					end
				end
				LOAD_PRG: begin
					if (mem_write) begin
						bytes_left <= bytes_left - 1'b1;
						mem_addr <= mem_addr + 1'b1;
					end else if (bytes_left == '0) begin
						if (chr_pages == 8'd0) begin // CHR RAM cart
							state <= LOAD_DONE;
							busy <= 1'b0;
							done <= 1'b1;
						end else begin
							state <= LOAD_CHR;
							mem_addr <= CHR_BASE;
							bytes_left <= ADDR_W'(chr_pages) << CHR_PAGE_SHIFT;
						end
					end
				end
				LOAD_CHR: begin
					if (mem_write) begin
						bytes_left <= bytes_left - 1'b1;
						mem_addr <= mem_addr + 1'b1;
					end else if (bytes_left == '0) begin
						state <= LOAD_DONE;
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
				default: ; // Done and error hold until the next download
				endcase
			end
		end
	end

	// Flag word follows the parser while done is up
	always_ff @(posedge clk) begin
		if (reset_nes)
			mapper_flags <= '0;
		else if (done)
			mapper_flags <= flags;
	end

	a_no_write_when_finished: assert property (@(posedge clk) disable iff (reset_nes)
		(state == LOAD_DONE || state == LOAD_ERROR) |-> !mem_write);

endmodule

`default_nettype wire

// ==== design/loader_config_regs.sv ====
// Loader configuration registers on APB
// Control bits for mirroring, joypad swap and multitap,
// read-only loader status and mapper flags

`timescale 1ns/1ps
`default_nettype none

module loader_config_regs (
	input  wire logic                                  clk,
	input  wire logic                                  reset_nes,
	input  wire logic [nes_loader_pkg::APB_ADDR_W-1:0] paddr,
	input  wire logic                                  psel,
	input  wire logic                                  penable,
	input  wire logic                                  pwrite,
	input  wire logic [31:0]                           pwdata,
	input  wire logic                                  busy,
	input  wire logic                                  done,
	input  wire logic                                  error,
	input  wire logic [nes_loader_pkg::FLAGS_W-1:0]    mapper_flags,
	output logic [31:0]                                prdata,
	output logic                                       pready,
	output logic                                       pslverr,
	output logic                                       invert_mirroring,
	output logic                                       joy_swap,
	output logic                                       multitap
);
	import nes_loader_pkg::*;

	logic access;
	logic addr_hit;
	logic ctrl_wr;

	assign access = psel && penable;
	assign addr_hit = paddr == REG_CTRL || paddr == REG_STATUS || paddr == REG_FLAGS;
	assign ctrl_wr = access && pwrite && paddr == REG_CTRL;

	assign pready = access; // No wait states
	assign pslverr = access && (!addr_hit || (pwrite && paddr != REG_CTRL));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			invert_mirroring <= 1'b0;
			joy_swap <= 1'b0;
			multitap <= 1'b0;
		end else if (ctrl_wr) begin
			invert_mirroring <= pwdata[0];
			joy_swap <= pwdata[1];
			multitap <= pwdata[2];
		end
	end

	always_comb begin
		case (paddr)
		REG_CTRL:   prdata = {29'd0, multitap, joy_swap, invert_mirroring};
		REG_STATUS: prdata = {29'd0, error, done, busy};
		REG_FLAGS:  prdata = 32'(mapper_flags);
		default:    prdata = 32'd0;
		endcase
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (reset_nes)
		penable |-> psel);

endmodule

`default_nettype wire

// ==== design/joypad_serial.sv ====
// Joypad serialiser for the two console ports
// Loads 24-bit shift registers on strobe and shifts on falling clock edges

`timescale 1ns/1ps
`default_nettype none

module joypad_serial (
	input  wire logic        clk,
	input  wire logic        reset_nes,
	input  wire logic [31:0] joy_pads,
	input  wire logic        joypad_strobe,
	input  wire logic [1:0]  joypad_clock,
	input  wire logic        joy_swap,
	input  wire logic        multitap,
	output logic [1:0]       joypad_data
);
	import nes_loader_pkg::*;

	logic [7:0]  nes_pad [4];
	logic [23:0] load_val [2];
	logic [23:0] shift_q [2];
	logic [1:0]  clock_q;

	// Host order has the d-pad as Right, Left, Down, Up
	function automatic logic [7:0] nes_order(input logic [7:0] host);
		return {host[4], host[5], host[6], host[7], host[3:0]};
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++)
			nes_pad[i] = nes_order(joy_pads[i*8 +: 8]);
	end

	// Port 1 reads pads A and C, port 2 pads B and D
	assign load_val[0] = {multitap ? {MULTITAP_SIG_P1, nes_pad[2]} : 16'hFFFF,
		joy_swap ? nes_pad[1] : nes_pad[0]};
	assign load_val[1] = {multitap ? {MULTITAP_SIG_P2, nes_pad[3]} : 16'hFFFF,
		joy_swap ? nes_pad[0] : nes_pad[1]};

	always_ff @(posedge clk) begin
		if (reset_nes)
			clock_q <= 2'b00;
		else
			clock_q <= joypad_clock;
	end

	for (genvar p = 0; p < 2; p++) begin : g_port
		always_ff @(posedge clk) begin
			if (reset_nes)
				shift_q[p] <= 24'd0;
			else if (joypad_strobe)
				shift_q[p] <= load_val[p]; // Held in load while strobe is high
			else if (clock_q[p] && !joypad_clock[p])
				shift_q[p] <= {1'b0, shift_q[p][23:1]};
		end

		assign joypad_data[p] = shift_q[p][0];
	end

endmodule

`default_nettype wire

// ==== design/nes_input_top.sv ====
// NES cartridge loader and controller front end
// Ties the ROM loader, the APB config registers and the joypad serialiser

`timescale 1ns/1ps
`default_nettype none

module nes_input_top (
	input  wire logic                                  clk,
	input  wire logic                                  reset_nes,
	input  wire logic                                  download,
	input  wire logic                                  file_valid,
	input  wire logic [7:0]                            file_data,
	output logic [nes_loader_pkg::ADDR_W-1:0]          mem_addr,
	output logic [7:0]                                 mem_data,
	output logic                                       mem_write,
	input  wire logic [nes_loader_pkg::APB_ADDR_W-1:0] paddr,
	input  wire logic                                  psel,
	input  wire logic                                  penable,
	input  wire logic                                  pwrite,
	input  wire logic [31:0]                           pwdata,
	output logic [31:0]                                prdata,
	output logic                                       pready,
	output logic                                       pslverr,
	input  wire logic [31:0]                           joy_pads,
	input  wire logic                                  joypad_strobe,
	input  wire logic [1:0]                            joypad_clock,
	output logic [1:0]                                 joypad_data
);
	import nes_loader_pkg::*;

	logic               invert_mirroring;
	logic               joy_swap;
	logic               multitap;
	logic               busy;
	logic               done;
	logic               error;
	logic [FLAGS_W-1:0] mapper_flags;

	rom_loader u_rom_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.file_valid       (file_valid),
		.file_data        (file_data),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags)
	);

	loader_config_regs u_loader_config_regs (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.paddr            (paddr),
		.psel             (psel),
		.penable          (penable),
		.pwrite           (pwrite),
		.pwdata           (pwdata),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.prdata           (prdata),
		.pready           (pready),
		.pslverr          (pslverr),
		.invert_mirroring (invert_mirroring),
		.joy_swap         (joy_swap),
		.multitap         (multitap)
	);

	joypad_serial u_joypad_serial (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_pads      (joy_pads),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joy_swap      (joy_swap),
		.multitap      (multitap),
		.joypad_data   (joypad_data)
	);

endmodule

`default_nettype wire

// ==== verif/tb_nes_input.sv ====
// Testbench for the NES cartridge loader and controller front end
// Loads iNES files from the vector file, checks memory writes, APB registers
// and the serial joypad ports

`timescale 1ns/1ps
`default_nettype none

module tb_nes_input;
	import nes_loader_pkg::*;

	localparam int MAX_POLLS = 50;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;
	localparam int ERR_PAYLOAD = 64; // Bytes sent after a rejected header
	localparam logic [21:0] PRG_START = 22'h000000;
	localparam logic [21:0] CHR_START = 22'h200000;

	logic                  clk;
	logic                  reset_nes;
	logic                  download;
	logic                  file_valid;
	logic [7:0]            file_data;
	logic [ADDR_W-1:0]     mem_addr;
	logic [7:0]            mem_data;
	logic                  mem_write;
	logic [APB_ADDR_W-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;
	logic [31:0]           joy_pads;
	logic                  joypad_strobe;
	logic [1:0]            joypad_clock;
	logic [1:0]            joypad_data;

	// Vectors from the data file
	string        name_q [$];
	logic [2:0]   ctrl_q [$];
	logic [127:0] hdr_q [$];
	logic [25:0]  flags_q [$];
	logic         err_q [$];
	logic [31:0]  pads_q [$];

	// Writes still owed by the DUT
	logic [ADDR_W-1:0] exp_addr_q [$];
	logic [7:0]        exp_data_q [$];

	int    seed = 32'h4268de1e;
	int    error_count = 0;
	int    write_count = 0;
	int    cycle_count = 0;
	int    timeout_limit = 2000;
	int    tests_run = 0;
	int    tests_failed = 0;
	string cur_name = "reset";

	nes_input_top u_nes_input_top (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.download      (download),
		.file_valid    (file_valid),
		.file_data     (file_data),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_write     (mem_write),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.joy_pads      (joy_pads),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout: run passed %0d cycles without finishing", timeout_limit);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: %s expected %h actual %h", cur_name, what, expected, actual);
		error_count++;
	endtask

	// Memory writes sampled mid cycle
	always @(negedge clk) begin
		if (!reset_nes && mem_write) begin
			write_count++;
			if (exp_data_q.size() == 0) begin
				$display("%s: unexpected memory write at address %h", cur_name, mem_addr);
				error_count++;
			end else begin
				if (mem_addr != exp_addr_q[0])
					report_mismatch("write address", 32'(exp_addr_q[0]), 32'(mem_addr));
				if (mem_data != exp_data_q[0])
					report_mismatch("write data", 32'(exp_data_q[0]), 32'(mem_data));
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	// Host order A, B, Select, Start, Right, Left, Down, Up into console order
	function automatic logic [7:0] to_nes_order(input logic [7:0] host);
		logic [7:0] nes;
		nes[3:0] = host[3:0];
		nes[4] = host[7]; // Up
		nes[5] = host[6]; // Down
		nes[6] = host[5]; // Left
		nes[7] = host[4]; // Right
		return nes;
	endfunction

	function automatic logic [23:0] expected_serial(input int port, input logic [31:0] pads,
		input logic swap, input logic mtap);
		logic [7:0] first;
		logic [7:0] second;
		logic [7:0] sig;
		if (port == 0) begin
			first = swap ? pads[15:8] : pads[7:0];
			second = pads[23:16];
			sig = 8'h08;
		end else begin
			first = swap ? pads[7:0] : pads[15:8];
			second = pads[31:24];
			sig = 8'h04;
		end
		if (mtap)
			return {sig, to_nes_order(second), to_nes_order(first)};
		else
			return {16'hFFFF, to_nes_order(first)};
	endfunction

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic slverr);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		if (!pready) begin
			$display("%s: APB write got no pready", cur_name);
			error_count++;
		end
		slverr = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic slverr);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		if (!pready) begin
			$display("%s: APB read got no pready", cur_name);
			error_count++;
		end
		data = prdata;
		slverr = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_testdata();
		int         fd;
		int         n;
		string      line;
		string      name;
		logic [7:0] hb [16];
		logic [2:0] ctrl;
		logic [25:0] flags;
		logic       err;
		logic [31:0] pads;
		logic [127:0] hdr;
		fd = $fopen("verif/loader_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file verif/loader_testdata.txt");
			error_count++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name, ctrl, hb[0], hb[1], hb[2], hb[3], hb[4], hb[5], hb[6], hb[7],
					hb[8], hb[9], hb[10], hb[11], hb[12], hb[13], hb[14], hb[15],
					flags, err, pads);
				if (n != 21) begin
					$display("Malformed line in test data file: %s", line);
					error_count++;
				end else begin
					for (int i = 0; i < 16; i++)
						hdr[8*i +: 8] = hb[i];
					name_q.push_back(name);
					ctrl_q.push_back(ctrl);
					hdr_q.push_back(hdr);
					flags_q.push_back(flags);
					err_q.push_back(err);
					pads_q.push_back(pads);
					timeout_limit += 16 + int'(hb[4]) * PRG_PAGE_BYTES +
						int'(hb[5]) * CHR_PAGE_BYTES;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic send_payload(input int count, input logic [ADDR_W-1:0] base);
		logic [7:0] b;
		for (int i = 0; i < count; i++) begin
			b = 8'($random(seed));
			@(posedge clk);
			file_valid <= 1'b1;
			file_data <= b;
			exp_addr_q.push_back(base + ADDR_W'(i));
			exp_data_q.push_back(b);
		end
	endtask

	task automatic send_file(input int idx);
		logic [127:0] hdr;
		int           prg_bytes;
		int           chr_bytes;
		hdr = hdr_q[idx];
		prg_bytes = int'(hdr[39:32]) * PRG_PAGE_BYTES;
		chr_bytes = int'(hdr[47:40]) * CHR_PAGE_BYTES;
		@(posedge clk);
		download <= 1'b1; // Rising edge restarts the loader
		file_valid <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			file_valid <= 1'b1;
			file_data <= hdr[8*i +: 8];
		end
		@(posedge clk);
		file_valid <= 1'b0; // Header evaluation cycle
		if (err_q[idx]) begin
			// Nothing of a rejected file may reach memory
			for (int i = 0; i < ERR_PAYLOAD; i++) begin
				@(posedge clk);
				file_valid <= 1'b1;
				file_data <= 8'($random(seed));
			end
		end else begin
			send_payload(prg_bytes, PRG_START);
			if (chr_bytes > 0) begin
				@(posedge clk);
				file_valid <= 1'b0; // Idle step from PRG to CHR
				send_payload(chr_bytes, CHR_START);
			end
		end
		@(posedge clk);
		file_valid <= 1'b0;
		download <= 1'b0;
	endtask

	task automatic wait_for_done(output logic [31:0] status, output logic finished);
		logic slverr;
		int   polls;
		finished = 1'b0;
		polls = 0;
		while (!finished && polls < MAX_POLLS) begin
			apb_read(REG_STATUS, status, slverr);
			finished = status[1];
			polls++;
		end
	endtask

	task automatic check_joypad(input int idx);
		logic [23:0] exp_bits [2];
		logic [23:0] got_bits [2];
		logic        swap;
		logic        mtap;
		swap = ctrl_q[idx][1];
		mtap = ctrl_q[idx][2];
		exp_bits[0] = expected_serial(0, pads_q[idx], swap, mtap);
		exp_bits[1] = expected_serial(1, pads_q[idx], swap, mtap);
		@(posedge clk);
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		for (int k = 0; k < 24; k++) begin
			@(negedge clk);
			got_bits[0][k] = joypad_data[0];
			got_bits[1][k] = joypad_data[1];
			@(posedge clk);
			joypad_clock <= 2'b11;
			@(posedge clk);
			joypad_clock <= 2'b00;
			@(posedge clk); // Shift lands one cycle after the falling edge
		end
		@(negedge clk);
		if (joypad_data != 2'b00)
			report_mismatch("joypad data once shifted empty", 32'd0, 32'(joypad_data));
		if (got_bits[0] != exp_bits[0])
			report_mismatch("joypad port 1 bits", 32'(exp_bits[0]), 32'(got_bits[0]));
		if (got_bits[1] != exp_bits[1])
			report_mismatch("joypad port 2 bits", 32'(exp_bits[1]), 32'(got_bits[1]));
	endtask

	task automatic finish_test(input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("PASS %s", cur_name);
		end else begin
			tests_failed++;
			$display("FAIL %s", cur_name);
		end
	endtask

	task automatic run_apb_test();
		logic [31:0] rd;
		logic        slverr;
		int          start_errors;
		start_errors = error_count;
		cur_name = "apb_regs";
		apb_read(REG_STATUS, rd, slverr);
		if (rd != 32'd0)
			report_mismatch("status after reset", 32'd0, rd);
		apb_read(REG_CTRL, rd, slverr);
		if (rd != 32'd0)
			report_mismatch("control after reset", 32'd0, rd);
		if (joypad_data != 2'b00)
			report_mismatch("joypad data after reset", 32'd0, 32'(joypad_data));
		apb_write(REG_CTRL, 32'h5, slverr);
		if (slverr) begin
			$display("%s: write to the control register raised pslverr", cur_name);
			error_count++;
		end
		apb_read(REG_CTRL, rd, slverr);
		if (rd != 32'h5)
			report_mismatch("control readback", 32'h5, rd);
		apb_write(REG_STATUS, 32'h7, slverr);
		if (!slverr) begin
			$display("%s: write to the read-only status register raised no pslverr", cur_name);
			error_count++;
		end
		apb_read(4'hC, rd, slverr);
		if (!slverr) begin
			$display("%s: read of an unmapped address raised no pslverr", cur_name);
			error_count++;
		end
		apb_write(REG_CTRL, 32'h0, slverr);
		finish_test(start_errors);
	endtask

	task automatic run_load_test(input int idx);
		logic [31:0]  rd;
		logic         slverr;
		logic         finished;
		logic [127:0] hdr;
		int           start_errors;
		int           exp_writes;
		start_errors = error_count;
		cur_name = name_q[idx];
		hdr = hdr_q[idx];
		write_count = 0;
		if (err_q[idx])
			exp_writes = 0;
		else
			exp_writes = int'(hdr[39:32]) * PRG_PAGE_BYTES + int'(hdr[47:40]) * CHR_PAGE_BYTES;
		@(posedge clk);
		joy_pads <= pads_q[idx];
		apb_write(REG_CTRL, 32'(ctrl_q[idx]), slverr);
		apb_read(REG_CTRL, rd, slverr);
		if (rd != 32'(ctrl_q[idx]))
			report_mismatch("control readback", 32'(ctrl_q[idx]), rd);
		send_file(idx);
		wait_for_done(rd, finished);
		if (!finished) begin
			$display("%s: loader never reported done", cur_name);
			error_count++;
		end
		if (rd != {29'd0, err_q[idx], 2'b10}) // Error, done, busy
			report_mismatch("status", {29'd0, err_q[idx], 2'b10}, rd);
		if (!err_q[idx]) begin
			apb_read(REG_FLAGS, rd, slverr);
			if (rd != 32'(flags_q[idx]))
				report_mismatch("mapper flags", 32'(flags_q[idx]), rd);
		end
		if (write_count != exp_writes)
			report_mismatch("write count", exp_writes, write_count);
		if (exp_data_q.size() != 0) begin
			$display("%s: %0d expected memory writes never happened", cur_name,
				exp_data_q.size());
			error_count++;
			exp_addr_q.delete();
			exp_data_q.delete();
		end
		check_joypad(idx);
		finish_test(start_errors);
	endtask

	initial begin
		reset_nes = 1'b1;
		download = 1'b0;
		file_valid = 1'b0;
		file_data = 8'h00;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		joy_pads = 32'd0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		read_testdata();
		if (name_q.size() == 0) begin
			$display("No load tests found in the test data file");
			error_count++;
		end
		repeat (5) @(posedge clk);
		reset_nes <= 1'b0;
		run_apb_test();
		for (int i = 0; i < name_q.size(); i++)
			run_load_test(i);
		$display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
common/nes_loader_pkg.sv
loader/ines_header_parser.sv
loader/rom_loader.sv
design/loader_config_regs.sv
design/joypad_serial.sv
design/nes_input_top.sv
verif/tb_nes_input.sv

// ==== run.sh ====
#!/bin/sh
# Build the NES loader testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_nes_input -f src.f

out=$(./obj_dir/Vtb_nes_input)
echo "$out"
echo "$out" | grep -q 'All tests passed!'

// ==== verif/loader_testdata.txt ====
# name ctrl hdr0 .. hdr15 (hex bytes) expected_flags expected_error joy_pads
# ctrl bit 0 invert mirroring, bit 1 joypad swap, bit 2 multitap
nrom_basic    0 4E 45 53 1A 01 01 13 00 00 00 00 00 00 00 00 00 2004001 0 12345678
nrom_invert   1 4E 45 53 1A 01 01 13 00 00 00 00 00 00 00 00 00 2000001 0 A5C30F81
chr_ram       2 4E 45 53 1A 01 00 20 10 00 00 00 00 00 00 00 00 0008012 0 80402010
prg_two_pages 4 4E 45 53 1A 02 01 08 00 00 00 00 00 00 00 00 00 0010100 0 F00F55AA
ines2_header  6 4E 45 53 1A 01 01 41 48 21 00 07 00 00 00 00 00 0424044 0 0123CDEF
dirty_header  3 4E 45 53 1A 01 01 30 50 99 00 00 00 44 00 00 00 0004003 0 FF00FF00
bad_magic     0 4E 45 53 1B 01 01 00 00 00 00 00 00 00 00 00 00 0000000 1 DEADBEEF
trainer_set   5 4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 0000000 1 3C3C9696
